// File: design/mips_pkg.sv
// opcodes, function codes, ALU and result select encodings, instruction union, ALU functions
package mips_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int DATA_W     = 32;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;

    // function field of SPECIAL
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'b00000000,
        ALU_OR   = 8'b00100101,
        ALU_AND  = 8'b00100100,
        ALU_XOR  = 8'b00100110,
        ALU_NOR  = 8'b00100111,
        ALU_LUI  = 8'b01011100,
        ALU_ADDU = 8'b00100001,
        ALU_SUBU = 8'b00100011
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_ARITH = 3'b100
    } alusel_e;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } itype_t;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rtype_t;

    // same word seen as I-type or R-type
    typedef union packed {
        itype_t i;
        rtype_t r;
    } instr_t;

    function automatic logic [DATA_W-1:0] logic_unit(aluop_e op, logic [DATA_W-1:0] a,
                                                     logic [DATA_W-1:0] b);
        case (op)
            ALU_OR:  return a | b;
            ALU_AND: return a & b;
            ALU_XOR: return a ^ b;
            ALU_NOR: return ~(a | b);
            ALU_LUI: return b;  // immediate already moved to the upper half
            default: return '0;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] arith_unit(aluop_e op, logic [DATA_W-1:0] a,
                                                     logic [DATA_W-1:0] b);
        case (op)
            ALU_ADDU: return a + b;  // wraps mod 2^32
            ALU_SUBU: return a - b;
            default:  return '0;
        endcase
    endfunction

    // result of one operation, picked by its class
    function automatic logic [DATA_W-1:0] alu_result(aluop_e op, alusel_e sel,
                                                     logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
        case (sel)
            SEL_LOGIC: return logic_unit(op, a, b);
            SEL_ARITH: return arith_unit(op, a, b);
            default:   return '0;
        endcase
    endfunction

endpackage

// File: design/pc_reg.sv
// program counter stepping by one word per accepted instruction
`timescale 1ns/10ps

module pc_reg #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid_i,
    output logic [31:0] pc_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_next;

    // no back-pressure, every strobe is a fetch
    always_comb begin
        pc_next = pc_q;
        if (inst_valid_i) begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;  // address of the word on inst_i

endmodule

// File: design/regfile.sv
// 32x32 register file, two read ports, one write port with write-through
`timescale 1ns/10ps

module regfile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            re1_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic                            re2_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr2_i,
    input  logic                            we_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [mips_pkg::DATA_W-1:0]     wdata_i,
    output logic [mips_pkg::DATA_W-1:0]     rdata1_o,
    output logic [mips_pkg::DATA_W-1:0]     rdata2_o
);

    logic [mips_pkg::DATA_W-1:0] regs [2**mips_pkg::REG_ADDR_W];

    // one read port, r0 is hardwired to zero
    function automatic logic [mips_pkg::DATA_W-1:0] read_port(
        input logic                            re,
        input logic [mips_pkg::REG_ADDR_W-1:0] addr,
        input logic [mips_pkg::DATA_W-1:0]     stored,
        input logic                            we,
        input logic [mips_pkg::REG_ADDR_W-1:0] waddr,
        input logic [mips_pkg::DATA_W-1:0]     wdata
    );
        if (!re || addr == '0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;  // write lands this edge, hand it over now
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**mips_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = read_port(re1_i, raddr1_i, regs[raddr1_i], we_i, waddr_i, wdata_i);
    assign rdata2_o = read_port(re2_i, raddr2_i, regs[raddr2_i], we_i, waddr_i, wdata_i);

endmodule

// File: design/instr_decode.sv
// instruction decode, immediate extension, forwarded operand select, decode registers
`timescale 1ns/10ps

module instr_decode (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [31:0]                     pc_i,
    input  logic [31:0]                     inst_i,
    input  logic                            inst_valid_i,
    input  logic [mips_pkg::DATA_W-1:0]     reg1_data_i,
    input  logic [mips_pkg::DATA_W-1:0]     reg2_data_i,
    input  logic                            ex_we_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_waddr_i,
    input  logic [mips_pkg::DATA_W-1:0]     ex_wdata_i,
    output logic                            reg1_read_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] reg1_addr_o,
    output logic                            reg2_read_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] reg2_addr_o,
    output mips_pkg::aluop_e                aluop_o,
    output mips_pkg::alusel_e               alusel_o,
    output logic [mips_pkg::DATA_W-1:0]     reg1_o,
    output logic [mips_pkg::DATA_W-1:0]     reg2_o,
    output logic                            wreg_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] wd_o
);

    mips_pkg::instr_t  ins;
    mips_pkg::aluop_e  d_aluop;
    mips_pkg::alusel_e d_alusel;
    logic                            d_wreg;
    logic [mips_pkg::REG_ADDR_W-1:0] d_wd;
    logic                            d_re1;
    logic                            d_re2;
    logic [mips_pkg::DATA_W-1:0]     d_imm;
    logic [mips_pkg::DATA_W-1:0]     zext_imm;
    logic [mips_pkg::DATA_W-1:0]     sext_imm;
    logic [mips_pkg::DATA_W-1:0]     lui_imm;
    logic [mips_pkg::DATA_W-1:0]     prev_res;
    logic [mips_pkg::DATA_W-1:0]     op1;
    logic [mips_pkg::DATA_W-1:0]     op2;
    logic                            slot_ok;

    // newest producer first: instruction in decode regs, then write-back, then regfile
    function automatic logic [mips_pkg::DATA_W-1:0] pick_operand(
        input logic                            re,
        input logic [mips_pkg::REG_ADDR_W-1:0] addr,
        input logic [mips_pkg::DATA_W-1:0]     alt,
        input logic [mips_pkg::DATA_W-1:0]     rf_data,
        input logic                            d1_we,
        input logic [mips_pkg::REG_ADDR_W-1:0] d1_addr,
        input logic [mips_pkg::DATA_W-1:0]     d1_data,
        input logic                            ex_we,
        input logic [mips_pkg::REG_ADDR_W-1:0] ex_addr,
        input logic [mips_pkg::DATA_W-1:0]     ex_data
    );
        if (!re) begin
            return alt;
        end
        if (addr == '0) begin
            return '0;
        end
        if (d1_we && d1_addr == addr) begin
            return d1_data;
        end
        if (ex_we && ex_addr == addr) begin
            return ex_data;
        end
        return rf_data;
    endfunction

    assign ins      = inst_i;
    assign zext_imm = {16'h0000, ins.i.imm};
    assign sext_imm = {{16{ins.i.imm[15]}}, ins.i.imm};
    assign lui_imm  = {ins.i.imm, 16'h0000};
    assign slot_ok  = inst_valid_i;

    always_comb begin
        d_aluop  = mips_pkg::ALU_NOP;
        d_alusel = mips_pkg::SEL_NOP;
        d_wreg   = 1'b0;
        d_wd     = '0;
        d_re1    = 1'b0;
        d_re2    = 1'b0;
        d_imm    = zext_imm;
        if (slot_ok) begin
            case (ins.i.op)
                mips_pkg::OP_ORI, mips_pkg::OP_ANDI, mips_pkg::OP_XORI: begin
                    d_alusel = mips_pkg::SEL_LOGIC;
                    d_wreg   = 1'b1;
                    d_wd     = ins.i.rt;
                    d_re1    = 1'b1;
                    case (ins.i.op)
                        mips_pkg::OP_ORI:  d_aluop = mips_pkg::ALU_OR;
                        mips_pkg::OP_ANDI: d_aluop = mips_pkg::ALU_AND;
                        default:           d_aluop = mips_pkg::ALU_XOR;
                    endcase
                end
                mips_pkg::OP_LUI: begin
                    d_aluop  = mips_pkg::ALU_LUI;
                    d_alusel = mips_pkg::SEL_LOGIC;
                    d_wreg   = 1'b1;
                    d_wd     = ins.i.rt;
                    d_imm    = lui_imm;  // rs not read
                end
                mips_pkg::OP_ADDIU: begin
                    d_aluop  = mips_pkg::ALU_ADDU;
                    d_alusel = mips_pkg::SEL_ARITH;
                    d_wreg   = 1'b1;
                    d_wd     = ins.i.rt;
                    d_re1    = 1'b1;
                    d_imm    = sext_imm;
                end
                mips_pkg::OP_SPECIAL: begin
                    d_wd  = ins.r.rd;
                    d_re1 = 1'b1;
                    d_re2 = 1'b1;
                    d_wreg = 1'b1;
                    case (ins.r.funct)
                        mips_pkg::FN_OR:   d_aluop = mips_pkg::ALU_OR;
                        mips_pkg::FN_AND:  d_aluop = mips_pkg::ALU_AND;
                        mips_pkg::FN_XOR:  d_aluop = mips_pkg::ALU_XOR;
                        mips_pkg::FN_NOR:  d_aluop = mips_pkg::ALU_NOR;
                        mips_pkg::FN_ADDU: d_aluop = mips_pkg::ALU_ADDU;
                        mips_pkg::FN_SUBU: d_aluop = mips_pkg::ALU_SUBU;
                        default: begin
                            d_wreg = 1'b0;  // unknown funct is a bubble
                            d_re1  = 1'b0;
                            d_re2  = 1'b0;
                            d_wd   = '0;
                        end
                    endcase
                    if (d_aluop == mips_pkg::ALU_ADDU || d_aluop == mips_pkg::ALU_SUBU) begin
                        d_alusel = mips_pkg::SEL_ARITH;
                    end else if (d_aluop != mips_pkg::ALU_NOP) begin
                        d_alusel = mips_pkg::SEL_LOGIC;
                    end
                end
                default: ;  // anything else stays a bubble
            endcase
        end
    end

    // regfile read side
    assign reg1_read_o = d_re1;
    assign reg1_addr_o = ins.r.rs;
    assign reg2_read_o = d_re2;
    assign reg2_addr_o = ins.r.rt;

    // result of the instruction one slot ahead, still sitting in the decode regs
    assign prev_res = mips_pkg::alu_result(aluop_o, alusel_o, reg1_o, reg2_o);

    always_comb begin
        op1 = pick_operand(d_re1, reg1_addr_o, '0, reg1_data_i, wreg_o, wd_o, prev_res,
                           ex_we_i, ex_waddr_i, ex_wdata_i);
        op2 = pick_operand(d_re2, reg2_addr_o, d_imm, reg2_data_i, wreg_o, wd_o, prev_res,
                           ex_we_i, ex_waddr_i, ex_wdata_i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluop_o  <= mips_pkg::ALU_NOP;
            alusel_o <= mips_pkg::SEL_NOP;
            reg1_o   <= '0;
            reg2_o   <= '0;
            wreg_o   <= 1'b0;
            wd_o     <= '0;
        end else begin
            aluop_o  <= d_aluop;
            alusel_o <= d_alusel;
            reg1_o   <= d_wreg ? op1 : '0;  // bubbles carry zero operands
            reg2_o   <= d_wreg ? op2 : '0;
            wreg_o   <= d_wreg;
            wd_o     <= d_wd;
        end
    end

endmodule

// File: design/exec_unit.sv
// execute stage with logic and arithmetic units and registered write-back
`timescale 1ns/10ps

module exec_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  mips_pkg::aluop_e                aluop_i,
    input  mips_pkg::alusel_e               alusel_i,
    input  logic [mips_pkg::DATA_W-1:0]     reg1_i,
    input  logic [mips_pkg::DATA_W-1:0]     reg2_i,
    input  logic                            wreg_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wd_i,
    output logic                            wb_we_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] wb_waddr_o,
    output logic [mips_pkg::DATA_W-1:0]     wb_wdata_o
);

    logic [mips_pkg::DATA_W-1:0] logic_res;
    logic [mips_pkg::DATA_W-1:0] arith_res;
    logic [mips_pkg::DATA_W-1:0] result;
    logic                        we_next;

    assign logic_res = mips_pkg::logic_unit(aluop_i, reg1_i, reg2_i);  // or/and/xor/nor/lui
    assign arith_res = mips_pkg::arith_unit(aluop_i, reg1_i, reg2_i);  // addu/subu

    // class select
    always_comb begin
        case (alusel_i)
            mips_pkg::SEL_LOGIC: result = logic_res;
            mips_pkg::SEL_ARITH: result = arith_res;
            default:             result = '0;
        endcase
    end

    // r0 never written, so later stages skip that test
    assign we_next = wreg_i && (wd_i != '0) && (alusel_i != mips_pkg::SEL_NOP);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we_o    <= 1'b0;
            wb_waddr_o <= '0;
            wb_wdata_o <= '0;
        end else begin
            wb_we_o    <= we_next;
            wb_waddr_o <= wd_i;
            wb_wdata_o <= result;
        end
    end

endmodule

// File: design/mini_mips_top.sv
// core top with pc, decode, register file and execute stage
`timescale 1ns/10ps

module mini_mips_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [31:0]                     inst_i,
    input  logic                            inst_valid_i,
    output logic [31:0]                     pc_o,
    output logic                            wb_we_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] wb_waddr_o,
    output logic [mips_pkg::DATA_W-1:0]     wb_wdata_o
);

    logic                            re1;
    logic                            re2;
    logic [mips_pkg::REG_ADDR_W-1:0] raddr1;
    logic [mips_pkg::REG_ADDR_W-1:0] raddr2;
    logic [mips_pkg::DATA_W-1:0]     rdata1;
    logic [mips_pkg::DATA_W-1:0]     rdata2;
    mips_pkg::aluop_e                aluop;
    mips_pkg::alusel_e               alusel;
    logic [mips_pkg::DATA_W-1:0]     opnd1;
    logic [mips_pkg::DATA_W-1:0]     opnd2;
    logic                            wreg;
    logic [mips_pkg::REG_ADDR_W-1:0] wd;

    pc_reg #(.RESET_PC(RESET_PC)) u_pc (
        .clk(clk), .rst(rst), .inst_valid_i(inst_valid_i), .pc_o(pc_o)
    );

    instr_decode u_decode (
        .clk(clk), .rst(rst), .pc_i(pc_o), .inst_i(inst_i), .inst_valid_i(inst_valid_i),
        .reg1_data_i(rdata1), .reg2_data_i(rdata2),
        .ex_we_i(wb_we_o), .ex_waddr_i(wb_waddr_o), .ex_wdata_i(wb_wdata_o),  // forwarding
        .reg1_read_o(re1), .reg1_addr_o(raddr1), .reg2_read_o(re2), .reg2_addr_o(raddr2),
        .aluop_o(aluop), .alusel_o(alusel), .reg1_o(opnd1), .reg2_o(opnd2),
        .wreg_o(wreg), .wd_o(wd)
    );

    regfile u_regfile (
        .clk(clk), .rst(rst),
        .re1_i(re1), .raddr1_i(raddr1), .re2_i(re2), .raddr2_i(raddr2),
        .we_i(wb_we_o), .waddr_i(wb_waddr_o), .wdata_i(wb_wdata_o),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    exec_unit u_exec (
        .clk(clk), .rst(rst),
        .aluop_i(aluop), .alusel_i(alusel), .reg1_i(opnd1), .reg2_i(opnd2),
        .wreg_i(wreg), .wd_i(wd),
        .wb_we_o(wb_we_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o)
    );

endmodule

// File: dv/mini_mips_tb.sv
// testbench for mini_mips_top with reference model, write-back and pc assertions, watchdog
`timescale 1ns/10ps

module mini_mips_tb;

    localparam logic [31:0] START_PC       = 32'h0000_1000;
    localparam int          RAND_N         = 300;
    localparam int          MAX_GAP        = 3;
    localparam int          DIRECTED_SLOTS = 150;  // directed tests plus drains, rounded up
    localparam int          SLOT_BUDGET    = DIRECTED_SLOTS + RAND_N * (MAX_GAP + 1) + 10;
    localparam int          WATCHDOG_NS    = SLOT_BUDGET * 8 + 2000;

    logic        clk;
    logic        rst;
    logic [31:0] inst_i;
    logic        inst_valid_i;
    logic [31:0] pc_o;
    logic        wb_we_o;
    logic [4:0]  wb_waddr_o;
    logic [31:0] wb_wdata_o;

    logic [31:0] model_regs [32];
    logic        exp_in_we;
    logic [4:0]  exp_in_addr;
    logic [31:0] exp_in_data;
    logic        exp_we_q   [2];  // expected writes, two slots deep
    logic [4:0]  exp_addr_q [2];
    logic [31:0] exp_data_q [2];
    logic [31:0] acc_cnt;
    int          err_count;
    int          errs_mark;
    int          tests_run;
    int          tests_failed;
    int          issued;

    mini_mips_top #(.RESET_PC(START_PC)) UUT (
        .clk(clk), .rst(rst), .inst_i(inst_i), .inst_valid_i(inst_valid_i), .pc_o(pc_o),
        .wb_we_o(wb_we_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected write moves along with the instruction, accepted word is counted
    always @(posedge clk) begin
        if (rst) begin
            exp_we_q[0]   <= 1'b0;
            exp_we_q[1]   <= 1'b0;
            exp_addr_q[0] <= '0;
            exp_addr_q[1] <= '0;
            exp_data_q[0] <= '0;
            exp_data_q[1] <= '0;
            acc_cnt       <= '0;
        end else begin
            exp_we_q[0]   <= exp_in_we;
            exp_addr_q[0] <= exp_in_addr;
            exp_data_q[0] <= exp_in_data;
            exp_we_q[1]   <= exp_we_q[0];
            exp_addr_q[1] <= exp_addr_q[0];
            exp_data_q[1] <= exp_data_q[0];
            if (inst_valid_i) begin
                acc_cnt <= acc_cnt + 32'd1;
            end
        end
    end

    wb_check: assert property (@(posedge clk) disable iff (rst)
        (wb_we_o == exp_we_q[1]) &&
        (!exp_we_q[1] || (wb_waddr_o == exp_addr_q[1] && wb_wdata_o == exp_data_q[1])))
    else begin
        err_count++;
        $display("Error at %0t: wb we=%0b addr=%0d data=%h, expected we=%0b addr=%0d data=%h",
                 $time, $sampled(wb_we_o), $sampled(wb_waddr_o), $sampled(wb_wdata_o),
                 $sampled(exp_we_q[1]), $sampled(exp_addr_q[1]), $sampled(exp_data_q[1]));
    end

    pc_check: assert property (@(posedge clk) disable iff (rst)
        pc_o == START_PC + (acc_cnt << 2))
    else begin
        err_count++;
        $display("Error at %0t: pc_o=%h, expected %h", $time, $sampled(pc_o),
                 START_PC + ($sampled(acc_cnt) << 2));
    end

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        mips_pkg::instr_t w;
        w.i.op  = op;
        w.i.rs  = rs;
        w.i.rt  = rt;
        w.i.imm = imm;
        return w;
    endfunction

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] funct);
        mips_pkg::instr_t w;
        w.r.op    = mips_pkg::OP_SPECIAL;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.rd    = rd;
        w.r.shamt = '0;
        w.r.funct = funct;
        return w;
    endfunction

    // program-order reference, updates model_regs
    task automatic model_exec(input logic [31:0] word, input logic valid, output logic we,
                              output logic [4:0] waddr, output logic [31:0] wdata);
        mips_pkg::instr_t ins;
        mips_pkg::aluop_e op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [4:0]       dest;
        ins  = word;
        op   = mips_pkg::ALU_NOP;
        a    = model_regs[ins.i.rs];
        b    = {16'h0000, ins.i.imm};
        dest = ins.i.rt;
        case (ins.i.op)
            mips_pkg::OP_ORI:  op = mips_pkg::ALU_OR;
            mips_pkg::OP_ANDI: op = mips_pkg::ALU_AND;
            mips_pkg::OP_XORI: op = mips_pkg::ALU_XOR;
            mips_pkg::OP_LUI: begin
                op = mips_pkg::ALU_LUI;
                b  = {ins.i.imm, 16'h0000};
            end
            mips_pkg::OP_ADDIU: begin
                op = mips_pkg::ALU_ADDU;
                b  = {{16{ins.i.imm[15]}}, ins.i.imm};
            end
            mips_pkg::OP_SPECIAL: begin
                b    = model_regs[ins.r.rt];
                dest = ins.r.rd;
                case (ins.r.funct)
                    mips_pkg::FN_OR:   op = mips_pkg::ALU_OR;
                    mips_pkg::FN_AND:  op = mips_pkg::ALU_AND;
                    mips_pkg::FN_XOR:  op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_ADDU: op = mips_pkg::ALU_ADDU;
                    mips_pkg::FN_SUBU: op = mips_pkg::ALU_SUBU;
                    default:           op = mips_pkg::ALU_NOP;
                endcase
            end
            default: op = mips_pkg::ALU_NOP;
        endcase
        if (!valid) begin
            op = mips_pkg::ALU_NOP;
        end
        case (op)
            mips_pkg::ALU_OR:   wdata = a | b;
            mips_pkg::ALU_AND:  wdata = a & b;
            mips_pkg::ALU_XOR:  wdata = a ^ b;
            mips_pkg::ALU_NOR:  wdata = ~(a | b);
            mips_pkg::ALU_LUI:  wdata = b;
            mips_pkg::ALU_ADDU: wdata = a + b;
            mips_pkg::ALU_SUBU: wdata = a - b;
            default:            wdata = '0;
        endcase
        we    = (op != mips_pkg::ALU_NOP) && (dest != 5'd0);  // r0 writes vanish
        waddr = dest;
        if (we) begin
            model_regs[dest] = wdata;
        end
    endtask

    task automatic issue_slot(input logic [31:0] word, input logic valid);
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        model_exec(word, valid, we, waddr, wdata);
        @(posedge clk);
        inst_i       <= word;
        inst_valid_i <= valid;
        exp_in_we    <= we;
        exp_in_addr  <= waddr;
        exp_in_data  <= wdata;
        if (valid) begin
            issued++;
        end
    endtask

    task automatic bubbles(input int n);
        repeat (n) issue_slot(32'h0000_0000, 1'b0);
    endtask

    // lets the last result reach the checks, then reports
    task automatic close_test(input string name);
        int errs;
        bubbles(3);
        @(negedge clk);
        errs = err_count - errs_mark;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
        errs_mark = err_count;
    endtask

    function automatic logic [31:0] random_instr();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        int unsigned kind;
        rs   = 5'($urandom_range(0, 7));  // few registers, many hazards
        rt   = 5'($urandom_range(0, 7));
        rd   = 5'($urandom_range(0, 7));
        imm  = 16'($urandom());
        kind = $urandom_range(0, 11);
        case (kind)
            0:       return itype_word(mips_pkg::OP_ORI, rs, rt, imm);
            1:       return itype_word(mips_pkg::OP_ANDI, rs, rt, imm);
            2:       return itype_word(mips_pkg::OP_XORI, rs, rt, imm);
            3:       return itype_word(mips_pkg::OP_LUI, rs, rt, imm);
            4:       return itype_word(mips_pkg::OP_ADDIU, rs, rt, imm);
            5:       return rtype_word(rs, rt, rd, mips_pkg::FN_OR);
            6:       return rtype_word(rs, rt, rd, mips_pkg::FN_AND);
            7:       return rtype_word(rs, rt, rd, mips_pkg::FN_XOR);
            8:       return rtype_word(rs, rt, rd, mips_pkg::FN_NOR);
            9:       return rtype_word(rs, rt, rd, mips_pkg::FN_ADDU);
            10:      return rtype_word(rs, rt, rd, mips_pkg::FN_SUBU);
            default: return itype_word(6'b100011, rs, rt, imm);  // load, unsupported
        endcase
    endfunction

    task automatic after_reset();
        @(negedge clk);
        assert (pc_o == START_PC && !wb_we_o) else begin
            err_count++;
            $display("Error at %0t: after reset pc_o=%h wb_we_o=%0b, expected pc %h and no write",
                     $time, pc_o, wb_we_o, START_PC);
        end
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd1, 16'h0001), 1'b1);
        close_test("after_reset");
    endtask

    task automatic immediate_ops();
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd2, 16'h1234), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd3, 16'hf0f0), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_LUI, 5'd0, 5'd4, 16'hdead), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ADDIU, 5'd0, 5'd5, 16'hfffd), 1'b1);  // -3
        issue_slot(itype_word(mips_pkg::OP_XORI, 5'd1, 5'd6, 16'h8001), 1'b1);
        bubbles(3);
        issue_slot(itype_word(mips_pkg::OP_ANDI, 5'd2, 5'd7, 16'h0ff0), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_XORI, 5'd3, 5'd8, 16'hffff), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ADDIU, 5'd4, 5'd9, 16'h8000), 1'b1);
        close_test("immediate_ops");
    endtask

    task automatic register_ops();
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd10, 16'h00ff), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd11, 16'h0f0f), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_LUI, 5'd0, 5'd12, 16'h8123), 1'b1);
        bubbles(3);
        issue_slot(rtype_word(5'd10, 5'd11, 5'd13, mips_pkg::FN_OR), 1'b1);
        issue_slot(rtype_word(5'd10, 5'd11, 5'd14, mips_pkg::FN_AND), 1'b1);
        issue_slot(rtype_word(5'd10, 5'd12, 5'd15, mips_pkg::FN_XOR), 1'b1);
        issue_slot(rtype_word(5'd11, 5'd12, 5'd16, mips_pkg::FN_NOR), 1'b1);
        issue_slot(rtype_word(5'd12, 5'd12, 5'd17, mips_pkg::FN_ADDU), 1'b1);  // carry out lost
        issue_slot(rtype_word(5'd10, 5'd11, 5'd18, mips_pkg::FN_SUBU), 1'b1);  // below zero
        issue_slot(rtype_word(5'd0, 5'd12, 5'd19, mips_pkg::FN_SUBU), 1'b1);
        close_test("register_ops");
    endtask

    task automatic hazard_chain();
        issue_slot(itype_word(mips_pkg::OP_ADDIU, 5'd0, 5'd20, 16'd5), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ADDIU, 5'd20, 5'd20, 16'd7), 1'b1);  // distance 1
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd21, 16'h0100), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_XORI, 5'd0, 5'd9, 16'h0003), 1'b1);
        issue_slot(rtype_word(5'd21, 5'd20, 5'd22, mips_pkg::FN_ADDU), 1'b1);  // distance 2 and 3
        issue_slot(itype_word(mips_pkg::OP_LUI, 5'd0, 5'd23, 16'h00aa), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd9, 16'h0001), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd8, 16'h0002), 1'b1);
        issue_slot(rtype_word(5'd23, 5'd21, 5'd24, mips_pkg::FN_OR), 1'b1);  // distance 3
        issue_slot(rtype_word(5'd24, 5'd22, 5'd25, mips_pkg::FN_SUBU), 1'b1);
        issue_slot(rtype_word(5'd25, 5'd25, 5'd25, mips_pkg::FN_ADDU), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ADDIU, 5'd0, 5'd26, 16'd9), 1'b1);
        issue_slot(itype_word(mips_pkg::OP_ADDIU, 5'd0, 5'd26, 16'd1), 1'b0);  // gap slot
        issue_slot(rtype_word(5'd26, 5'd26, 5'd26, mips_pkg::FN_ADDU), 1'b1);
        close_test("hazard_chain");
    endtask

    task automatic zero_and_unknown();
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd0, 16'hffff), 1'b1);
        issue_slot(rtype_word(5'd2, 5'd3, 5'd0, mips_pkg::FN_ADDU), 1'b1);
        issue_slot(rtype_word(5'd0, 5'd0, 5'd27, mips_pkg::FN_OR), 1'b1);  // r0 still zero
        issue_slot(rtype_word(5'd0, 5'd2, 5'd28, mips_pkg::FN_ADDU), 1'b1);
        issue_slot(itype_word(6'b100011, 5'd1, 5'd29, 16'h0004), 1'b1);  // load opcode
        issue_slot(rtype_word(5'd1, 5'd2, 5'd29, 6'b000000), 1'b1);  // shift funct
        issue_slot(itype_word(mips_pkg::OP_ORI, 5'd0, 5'd29, 16'h7777), 1'b0);
        issue_slot(rtype_word(5'd29, 5'd0, 5'd30, mips_pkg::FN_OR), 1'b1);
        close_test("zero_and_unknown");
    endtask

    task automatic random_stream();
        int gap;
        for (int n = 0; n < RAND_N; n++) begin
            issue_slot(random_instr(), 1'b1);
            gap = int'($urandom_range(0, MAX_GAP));
            repeat (gap) issue_slot($urandom(), 1'b0);
        end
        bubbles(3);
        @(negedge clk);
        assert (pc_o == START_PC + (32'(issued) << 2)) else begin
            err_count++;
            $display("Error at %0t: pc_o=%h after %0d accepted words", $time, pc_o, issued);
        end
        close_test("random_stream");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h97d0e0e5));
        rst          = 1'b1;
        inst_i       = '0;
        inst_valid_i = 1'b0;
        exp_in_we    = 1'b0;
        exp_in_addr  = '0;
        exp_in_data  = '0;
        err_count    = 0;
        errs_mark    = 0;
        tests_run    = 0;
        tests_failed = 0;
        issued       = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        after_reset();
        immediate_ops();
        register_ops();
        hazard_chain();
        zero_and_unknown();
        random_stream();
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: mini_mips.f
design/mips_pkg.sv
design/pc_reg.sv
design/regfile.sv
design/instr_decode.sv
design/exec_unit.sv
design/mini_mips_top.sv
dv/mini_mips_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the mini_mips testbench with Verilator, run it, and check the log
set -u

cd "$(dirname "$0")" || exit 2

OBJ_DIR=obj_dir
BIN=mini_mips_sim
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 2
fi

verilator --binary --timing --assert -sv \
    -f mini_mips.f \
    --top-module mini_mips_tb \
    --Mdir "$OBJ_DIR" \
    -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit "$status"
fi

"./$OBJ_DIR/$BIN" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure"
exit 0
